// File: bench/controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module controller_tb;

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int N_INSTR = 300;
    localparam int MAX_CYCLES = 40000;

    // fetch side model states
    localparam int F_IDLE = 0, F_PCLD = 1, F_PCHOLD = 2, F_INTR0 = 3, F_INTR1 = 4;
    localparam int F_FETCH = 5, F_DEC = 6, F_EXEC = 7, F_OPW = 8, F_OPND = 9;
    // memory and writeback sides
    localparam int M_IDLE = 0, M_DISP = 1, M_WAIT = 2, M_XFER = 3, M_DONE = 4;
    localparam int M_PREQ = 5, M_PACK = 6;
    localparam int W_IDLE = 0, W_DISP = 1, W_MEM = 2, W_ONE = 3;

    logic    clk;
    logic    rst = 1'b1;
    opcode_t opcode = '0;
    logic    pc_w = 1'b0;
    logic    i_pending = 1'b0;
    logic    i_odv = 1'b0;
    logic    d_odv = 1'b0;
    logic    hs_in = 1'b0;
    mem_op_t st1 = MEM_NOP;
    wb_op_t  st2 = WB_NONE;

    fetch_ctrl_t fetch_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;
    logic        hs_out;

    fetch_ctrl_t exp_f;
    mem_ctrl_t   exp_m;
    wb_ctrl_t    exp_w;
    logic        exp_hs;

    int   f_st = F_IDLE, m_st = M_IDLE, w_st = W_IDLE;
    int   f_nx, m_nx, w_nx;
    int   f_cls = 0;
    logic m_wr = 1'b0, m_pin = 1'b0, m_fiq = 1'b0, m_fiq_nx, w_port = 1'b0;

    // responder delay counters
    int   i_cnt = 0, d_cnt = 0, h_cnt = 0;
    logic i_armed = 1'b0, d_armed = 1'b0, h_armed = 1'b0;
    logic hs_want;

    int cyc = 0;
    int wait_cycles;
    int n_exec = 0, n_two = 0, n_ill = 0, n_intr = 0, n_pcld = 0;
    int n_pout = 0, n_pin = 0, n_stall = 0;

    controller_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .pc_w       (pc_w),
        .i_pending  (i_pending),
        .i_odv      (i_odv),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .st1        (st1),
        .st2        (st2),
        .fetch_ctrl (fetch_ctrl),
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl),
        .hs_out     (hs_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_failed("output differs from the reference model");
        end
    endtask

    // class code is 0 for one-word, 1 for two-word and 2 for illegal
    function automatic int expected_class(input opcode_t op);
        int value;
        int cls;
        value = int'(op);
        cls = 0;
        if (value > 6'o55)
            cls = 2;
        else if ((value >= 6'o50) && (value <= 6'o52))
            cls = 1;
        else if ((value <= 6'o33) && ((value % 2) == 1))
            cls = 1;
        return cls;
    endfunction

    // mostly named codes with some arbitrary 5-bit ones
    function automatic mem_op_t draw_mem_op();
        int pick;
        pick = $urandom % 8;
        case (pick)
            0:       return MEM_NOP;
            1:       return MEM_LOAD;
            2:       return MEM_STORE;
            3:       return MEM_PORT_OUT;
            4:       return MEM_PORT_IN;
            default: return mem_op_t'($urandom);
        endcase
    endfunction

    // strobe 0 to 5 cycles into a request and then rearm
    task automatic answer_after_delay(input logic req, inout int cnt, inout logic armed,
                                      output logic strobe);
        strobe = 1'b0;
        if (!req)
            armed = 1'b0;
        else
        begin
            if (!armed)
            begin
                cnt = $urandom % 6;
                armed = 1'b1;
            end
            if (cnt == 0)
            begin
                strobe = 1'b1;
                armed = 1'b0;
            end
            else
                cnt = cnt - 1;
        end
    endtask

    ////////////////////////////////////////
    // check outputs then drive and advance the model
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        cyc = cyc + 1;
        if (cyc == 1)
            void'($urandom(32'h3f25));

        exp_f = '0;
        exp_f.i_req = (f_st == F_FETCH) || (f_st == F_OPW);
        exp_f.intr_save = (f_st == F_INTR0) || (f_st == F_INTR1);
        exp_f.pc_load = (f_st == F_PCLD);
        exp_f.decode = (f_st == F_DEC);
        exp_f.exec = (f_st == F_EXEC);
        exp_f.exec_two_word = (f_st == F_EXEC) && (f_cls == 1);
        exp_f.exec_illegal = (f_st == F_EXEC) && (f_cls == 2);
        exp_f.operand = (f_st == F_OPND);
        exp_m = '0;
        exp_m.d_req = (m_st == M_WAIT) || (m_st == M_XFER);
        exp_m.d_latch = (m_st == M_XFER);
        exp_m.d_write = m_wr && ((m_st == M_WAIT) || (m_st == M_XFER) || (m_st == M_DONE));
        exp_m.port_out = !m_pin && ((m_st == M_PREQ) || (m_st == M_PACK));
        exp_m.port_in = m_pin && ((m_st == M_PREQ) || (m_st == M_PACK));
        exp_hs = (m_st == M_PACK);
        exp_w = '0;
        exp_w.wb_en = (w_st == W_MEM) || (w_st == W_ONE);
        exp_w.wb_from_mem = (w_st == W_MEM);
        exp_w.wb_from_port = (w_st == W_ONE) && w_port;

        check_value("fetch_ctrl", 32'(fetch_ctrl), 32'(exp_f));
        check_value("mem_ctrl", 32'(mem_ctrl), 32'(exp_m));
        check_value("wb_ctrl", 32'(wb_ctrl), 32'(exp_w));
        check_value("hs_out", 32'(hs_out), 32'(exp_hs));

        // behaviors seen so far
        if (f_st == F_EXEC)
            n_exec = n_exec + 1;
        if (f_st == F_OPND)
            n_two = n_two + 1;
        if (exp_f.exec_illegal)
            n_ill = n_ill + 1;
        if (f_st == F_INTR0)
            n_intr = n_intr + 1;
        if (f_st == F_PCLD)
            n_pcld = n_pcld + 1;
        if ((m_st == M_PACK) && !m_pin)
            n_pout = n_pout + 1;
        if ((m_st == M_PACK) && m_pin)
            n_pin = n_pin + 1;
        if ((m_st == M_WAIT) && (w_st == W_MEM))
            n_stall = n_stall + 1;

        rst = (cyc < 8);
        if (f_st == F_IDLE)
        begin
            opcode = opcode_t'($urandom);
            pc_w = ($urandom % 4) == 0;
            i_pending = ($urandom % 4) == 0;
        end
        if (m_st == M_IDLE)
            st1 = draw_mem_op();
        if (w_st == W_IDLE)
            st2 = wb_op_t'($urandom);
        answer_after_delay(exp_f.i_req, i_cnt, i_armed, i_odv);
        answer_after_delay(exp_m.d_req, d_cnt, d_armed, d_odv);

        // port peer raises hs_in on a request and drops it once hs_out is up
        hs_want = (exp_m.port_out || exp_m.port_in) && !exp_hs;
        if (hs_in == hs_want)
            h_armed = 1'b0;
        else
        begin
            if (!h_armed)
            begin
                h_cnt = $urandom % 6;
                h_armed = 1'b1;
            end
            if (h_cnt == 0)
            begin
                hs_in = hs_want;
                h_armed = 1'b0;
            end
            else
                h_cnt = h_cnt - 1;
        end

        f_nx = f_st;
        case (f_st)
            F_IDLE:
            begin
                if (w_st == W_IDLE)
                    f_nx = pc_w ? F_PCLD : (i_pending ? F_INTR0 : F_FETCH);
            end
            F_PCLD:           f_nx = i_pending ? F_INTR0 : F_PCHOLD;
            F_PCHOLD,
            F_INTR1:          f_nx = F_FETCH;
            F_INTR0:          f_nx = F_INTR1;
            F_FETCH:          f_nx = i_odv ? F_DEC : F_FETCH;
            F_DEC:
            begin
                f_nx = F_EXEC;
                f_cls = expected_class(opcode);
            end
            F_EXEC:           f_nx = (f_cls == 1) ? F_OPW : F_IDLE;
            F_OPW:            f_nx = i_odv ? F_OPND : F_OPW;
            default:          f_nx = F_IDLE;
        endcase

        m_nx = m_st;
        case (m_st)
            M_IDLE:           m_nx = m_fiq ? M_DISP : M_IDLE;
            M_DISP:
            begin
                m_nx = M_IDLE;
                if ((st1 == MEM_LOAD) || (st1 == MEM_STORE))
                begin
                    m_nx = M_WAIT;
                    m_wr = (st1 == MEM_STORE);
                end
                else if ((st1 == MEM_PORT_OUT) || (st1 == MEM_PORT_IN))
                begin
                    m_nx = M_PREQ;
                    m_pin = (st1 == MEM_PORT_IN);
                end
            end
            M_WAIT:           m_nx = (w_st != W_MEM) ? M_XFER : M_WAIT;
            M_XFER:           m_nx = d_odv ? M_DONE : M_XFER;
            M_PREQ:           m_nx = hs_in ? M_PACK : M_PREQ;
            M_PACK:           m_nx = hs_in ? M_PACK : M_IDLE;
            default:          m_nx = M_IDLE;
        endcase
        m_fiq_nx = (f_st == F_IDLE);

        w_nx = w_st;
        case (w_st)
            W_IDLE:           w_nx = (m_st == M_IDLE) ? W_DISP : W_IDLE;
            W_DISP:
            begin
                w_nx = (st2 == WB_NONE) ? W_IDLE : ((st2 == WB_MEM) ? W_MEM : W_ONE);
                w_port = (st2 == WB_PORT);
            end
            W_MEM:            w_nx = d_odv ? W_IDLE : W_MEM;
            default:          w_nx = W_IDLE;
        endcase

        if (rst)
        begin
            f_st = F_IDLE;
            m_st = M_IDLE;
            w_st = W_IDLE;
            m_fiq = 1'b0;
        end
        else
        begin
            f_st = f_nx;
            m_st = m_nx;
            w_st = w_nx;
            m_fiq = m_fiq_nx;
        end
    end

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    initial
    begin
        wait_cycles = 0;
        while (rst)
        begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 20)
                stop_failed("reset was never released");
        end
        wait_cycles = 0;
        while (n_exec < N_INSTR)
        begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > MAX_CYCLES)
                stop_failed("timed out waiting for instructions to execute");
        end
        if ((n_two > 0) && (n_ill > 0) && (n_intr > 0) && (n_pcld > 0) && (n_pout > 0) &&
            (n_pin > 0) && (n_stall > 0))
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("two=%0d ill=%0d intr=%0d pcld=%0d pout=%0d pin=%0d stall=%0d",
                     n_two, n_ill, n_intr, n_pcld, n_pout, n_pin, n_stall);
            stop_failed("some behavior was never exercised");
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/fetch_decode_stage.sv
rtl/mem_stage.sv
rtl/writeback_stage.sv
rtl/controller_top.sv
bench/controller_tb.sv

// File: rtl/controller_top.sv
`timescale 1ns/100ps
`default_nettype none

module controller_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire isa_pkg::opcode_t    opcode,
    input  wire logic                pc_w,
    input  wire logic                i_pending,
    input  wire logic                i_odv,
    input  wire logic                d_odv,
    input  wire logic                hs_in,
    input  wire isa_pkg::mem_op_t    st1,
    input  wire isa_pkg::wb_op_t     st2,
    output ctrl_pkg::fetch_ctrl_t    fetch_ctrl,
    output ctrl_pkg::mem_ctrl_t      mem_ctrl,
    output ctrl_pkg::wb_ctrl_t       wb_ctrl,
    output logic                     hs_out
);

    // idle levels handed between stages
    logic fetch_idle;
    logic mem_idle;
    logic wb_idle;
    logic wb_data_ready;

    fetch_decode_stage fetch_i (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .pc_w       (pc_w),
        .i_pending  (i_pending),
        .i_odv      (i_odv),
        .wb_idle    (wb_idle),
        .fetch_idle (fetch_idle),
        .fetch_ctrl (fetch_ctrl)
    );

    mem_stage mem_i (
        .clk           (clk),
        .rst           (rst),
        .st1           (st1),
        .fetch_idle    (fetch_idle),
        .wb_data_ready (wb_data_ready),
        .d_odv         (d_odv),
        .hs_in         (hs_in),
        .mem_idle      (mem_idle),
        .mem_ctrl      (mem_ctrl),
        .hs_out        (hs_out)
    );

    writeback_stage wb_i (
        .clk           (clk),
        .rst           (rst),
        .st2           (st2),
        .mem_idle      (mem_idle),
        .d_odv         (d_odv),
        .wb_idle       (wb_idle),
        .wb_data_ready (wb_data_ready),
        .wb_ctrl       (wb_ctrl)
    );

endmodule

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    ////////////////////////////////////////
    // fetch/decode stage controls
    ////////////////////////////////////////

    typedef struct packed {
        // instruction word request, held until i_odv
        logic i_req;
        // interrupt entry, two cycles
        logic intr_save;
        logic pc_load;
        logic decode;
        logic exec;
        // class flags, only valid together with exec
        logic exec_two_word;
        logic exec_illegal;
        // second word of a two-word instruction has arrived
        logic operand;
    } fetch_ctrl_t;

    ////////////////////////////////////////
    // memory/port stage controls
    ////////////////////////////////////////

    typedef struct packed {
        logic d_req;
        logic d_write;
        // capture strobe while the data bus transfer is open
        logic d_latch;
        logic port_out;
        logic port_in;
    } mem_ctrl_t;

    ////////////////////////////////////////
    // writeback stage controls
    ////////////////////////////////////////

    typedef struct packed {
        logic wb_en;
        // source selects, both low means alu result
        logic wb_from_mem;
        logic wb_from_port;
    } wb_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/fetch_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_decode_stage (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire isa_pkg::opcode_t      opcode,
    input  wire logic                  pc_w,
    input  wire logic                  i_pending,
    input  wire logic                  i_odv,
    input  wire logic                  wb_idle,
    output logic                       fetch_idle,
    output ctrl_pkg::fetch_ctrl_t      fetch_ctrl
);

    import isa_pkg::*;

    typedef enum logic [3:0] {
        F_IDLE,
        F_PC_LOAD,
        F_PC_HOLD,
        F_INTR_0,
        F_INTR_1,
        F_FETCH,
        F_DECODE,
        F_EXEC_ONE,
        F_EXEC_TWO,
        F_EXEC_ILL,
        F_OPND_WAIT,
        F_OPND
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_nxt;

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= F_IDLE;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            F_IDLE:
            begin
                // hold off until writeback has drained
                if (wb_idle)
                begin
                    if (pc_w)
                        state_nxt = F_PC_LOAD;
                    else if (i_pending)
                        state_nxt = F_INTR_0;
                    else
                        state_nxt = F_FETCH;
                end
            end
            F_PC_LOAD:
            begin
                if (i_pending)
                    state_nxt = F_INTR_0;
                else
                    state_nxt = F_PC_HOLD;
            end
            F_PC_HOLD:   state_nxt = F_FETCH;
            F_INTR_0:    state_nxt = F_INTR_1;
            F_INTR_1:    state_nxt = F_FETCH;
            F_FETCH:
            begin
                if (i_odv)
                    state_nxt = F_DECODE;
            end
            F_DECODE:
            begin
                // the opcode picks which exec state follows
                case (classify_opcode(opcode))
                    CLS_TWO_WORD: state_nxt = F_EXEC_TWO;
                    CLS_ILLEGAL:  state_nxt = F_EXEC_ILL;
                    default:      state_nxt = F_EXEC_ONE;
                endcase
            end
            F_EXEC_TWO:  state_nxt = F_OPND_WAIT;
            F_OPND_WAIT:
            begin
                if (i_odv)
                    state_nxt = F_OPND;
            end
            F_EXEC_ONE,
            F_EXEC_ILL,
            F_OPND:      state_nxt = F_IDLE;
            default:     state_nxt = F_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // outputs, from state only
    ////////////////////////////////////////

    assign fetch_idle = (state == F_IDLE);

    always_comb
    begin
        fetch_ctrl = '0;
        case (state)
            F_PC_LOAD:   fetch_ctrl.pc_load = 1'b1;
            F_INTR_0,
            F_INTR_1:    fetch_ctrl.intr_save = 1'b1;
            F_FETCH,
            F_OPND_WAIT: fetch_ctrl.i_req = 1'b1;
            F_DECODE:    fetch_ctrl.decode = 1'b1;
            F_EXEC_ONE:  fetch_ctrl.exec = 1'b1;
            F_EXEC_TWO:
            begin
                fetch_ctrl.exec = 1'b1;
                fetch_ctrl.exec_two_word = 1'b1;
            end
            F_EXEC_ILL:
            begin
                fetch_ctrl.exec = 1'b1;
                fetch_ctrl.exec_illegal = 1'b1;
            end
            F_OPND:      fetch_ctrl.operand = 1'b1;
            default:     fetch_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // opcode field
    ////////////////////////////////////////

    localparam int opcode_w = 6;

    typedef logic [opcode_w-1:0] opcode_t;

    // last register-form opcode, odd ones carry an immediate word
    localparam opcode_t OPC_ALU_LAST = 6'o33;

    // two-word range above the register forms
    localparam opcode_t OPC_WIDE_FIRST = 6'o50;
    localparam opcode_t OPC_WIDE_LAST = 6'o52;

    // anything above this traps as illegal
    localparam opcode_t OPC_LEGAL_LAST = 6'o55;

    typedef enum logic [1:0] {
        CLS_ONE_WORD,
        CLS_TWO_WORD,
        CLS_ILLEGAL
    } op_class_t;

    function automatic op_class_t classify_opcode(opcode_t op);
        op_class_t cls;
        if (op > OPC_LEGAL_LAST)
            cls = CLS_ILLEGAL;
        else if ((op[0] && (op <= OPC_ALU_LAST)) ||
                 ((op >= OPC_WIDE_FIRST) && (op <= OPC_WIDE_LAST)))
            cls = CLS_TWO_WORD;
        else
            cls = CLS_ONE_WORD;
        return cls;
    endfunction

    ////////////////////////////////////////
    // memory stage operations
    ////////////////////////////////////////

    typedef logic [4:0] mem_op_t;

    localparam mem_op_t MEM_NOP = 5'd0;
    localparam mem_op_t MEM_LOAD = 5'd2;
    localparam mem_op_t MEM_STORE = 5'd12;
    localparam mem_op_t MEM_PORT_OUT = 5'd15;
    localparam mem_op_t MEM_PORT_IN = 5'd16;

    ////////////////////////////////////////
    // writeback operations
    ////////////////////////////////////////

    typedef logic [1:0] wb_op_t;

    localparam wb_op_t WB_NONE = 2'd0;
    localparam wb_op_t WB_MEM = 2'd1;
    localparam wb_op_t WB_ALU = 2'd2;
    localparam wb_op_t WB_PORT = 2'd3;

endpackage

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire isa_pkg::mem_op_t    st1,
    input  wire logic                fetch_idle,
    input  wire logic                wb_data_ready,
    input  wire logic                d_odv,
    input  wire logic                hs_in,
    output logic                     mem_idle,
    output ctrl_pkg::mem_ctrl_t      mem_ctrl,
    output logic                     hs_out
);

    import isa_pkg::*;

    typedef enum logic [3:0] {
        M_IDLE,
        M_DISPATCH,
        M_LD_WAIT,
        M_LD_XFER,
        M_LD_DONE,
        M_ST_WAIT,
        M_ST_XFER,
        M_ST_DONE,
        M_POUT_REQ,
        M_POUT_ACK,
        M_PIN_REQ,
        M_PIN_ACK
    } mem_state_t;

    mem_state_t state;
    mem_state_t state_nxt;
    logic       fetch_idle_q;

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    // one cycle behind the fetch stage
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= M_IDLE;
            fetch_idle_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            fetch_idle_q <= fetch_idle;
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            M_IDLE:
            begin
                if (fetch_idle_q)
                    state_nxt = M_DISPATCH;
            end
            M_DISPATCH:
            begin
                case (st1)
                    MEM_LOAD:     state_nxt = M_LD_WAIT;
                    MEM_STORE:    state_nxt = M_ST_WAIT;
                    MEM_PORT_OUT: state_nxt = M_POUT_REQ;
                    MEM_PORT_IN:  state_nxt = M_PIN_REQ;
                    // nop and unsupported codes
                    default:      state_nxt = M_IDLE;
                endcase
            end
            // data bus waits on writeback before opening a transfer
            M_LD_WAIT:  if (wb_data_ready) state_nxt = M_LD_XFER;
            M_LD_XFER:  if (d_odv)         state_nxt = M_LD_DONE;
            M_ST_WAIT:  if (wb_data_ready) state_nxt = M_ST_XFER;
            M_ST_XFER:  if (d_odv)         state_nxt = M_ST_DONE;
            // four-phase port handshake
            M_POUT_REQ: if (hs_in)         state_nxt = M_POUT_ACK;
            M_POUT_ACK: if (!hs_in)        state_nxt = M_IDLE;
            M_PIN_REQ:  if (hs_in)         state_nxt = M_PIN_ACK;
            M_PIN_ACK:  if (!hs_in)        state_nxt = M_IDLE;
            M_LD_DONE,
            M_ST_DONE:  state_nxt = M_IDLE;
            default:    state_nxt = M_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // outputs, from state only
    ////////////////////////////////////////

    assign mem_idle = (state == M_IDLE);
    assign hs_out = (state == M_POUT_ACK) || (state == M_PIN_ACK);

    always_comb
    begin
        mem_ctrl = '0;
        case (state)
            M_LD_WAIT:  mem_ctrl.d_req = 1'b1;
            M_LD_XFER:
            begin
                mem_ctrl.d_req = 1'b1;
                mem_ctrl.d_latch = 1'b1;
            end
            M_ST_WAIT:
            begin
                mem_ctrl.d_req = 1'b1;
                mem_ctrl.d_write = 1'b1;
            end
            M_ST_XFER:
            begin
                mem_ctrl.d_req = 1'b1;
                mem_ctrl.d_latch = 1'b1;
                mem_ctrl.d_write = 1'b1;
            end
            M_ST_DONE:  mem_ctrl.d_write = 1'b1;
            M_POUT_REQ,
            M_POUT_ACK: mem_ctrl.port_out = 1'b1;
            M_PIN_REQ,
            M_PIN_ACK:  mem_ctrl.port_in = 1'b1;
            default:    mem_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire isa_pkg::wb_op_t    st2,
    input  wire logic               mem_idle,
    input  wire logic               d_odv,
    output logic                    wb_idle,
    output logic                    wb_data_ready,
    output ctrl_pkg::wb_ctrl_t      wb_ctrl
);

    import isa_pkg::*;

    typedef enum logic [2:0] {
        W_IDLE,
        W_DISPATCH,
        W_MEM,
        W_ALU,
        W_PORT
    } wb_state_t;

    wb_state_t state;
    wb_state_t state_nxt;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= W_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            W_IDLE:     if (mem_idle) state_nxt = W_DISPATCH;
            W_DISPATCH:
            begin
                case (st2)
                    WB_MEM:  state_nxt = W_MEM;
                    WB_ALU:  state_nxt = W_ALU;
                    WB_PORT: state_nxt = W_PORT;
                    default: state_nxt = W_IDLE;
                endcase
            end
            // stay on the write port until memory data shows up
            W_MEM:      if (d_odv) state_nxt = W_IDLE;
            default:    state_nxt = W_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // outputs, from state only
    ////////////////////////////////////////

    assign wb_idle = (state == W_IDLE);
    assign wb_data_ready = (state != W_MEM);

    always_comb
    begin
        wb_ctrl = '0;
        wb_ctrl.wb_en = (state == W_MEM) || (state == W_ALU) || (state == W_PORT);
        wb_ctrl.wb_from_mem = (state == W_MEM);
        wb_ctrl.wb_from_port = (state == W_PORT);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module controller_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcontroller_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "FAIL: testbench reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi
echo "PASS"
exit 0
